//--- Bender.yml
package:
  name: coupe_asic

sources:
  # RTL in compile order
  - files:
      - logic/coupe_pkg.sv
      - logic/port_write_capture.sv
      - logic/asic_port_regs.sv
      - logic/memory_mapper.sv
      - logic/audio_out.sv
      - logic/coupe_asic.sv

  # Testbench with its reference model header
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/coupe_asic_tb.sv

//--- compile.f
+incdir+dv
logic/coupe_pkg.sv
logic/port_write_capture.sv
logic/asic_port_regs.sv
logic/memory_mapper.sv
logic/audio_out.sv
logic/coupe_asic.sv
dv/coupe_asic_tb.sv

//--- dv/coupe_asic_model.svh
/*
 * SAM Coupe ASIC reference model
 * Expected memory mapping, port read-back and audio mix.
 */

`ifndef COUPE_ASIC_MODEL_SVH
`define COUPE_ASIC_MODEL_SVH

// Mapping of one access under a given paging state
function automatic coupe_pkg::mem_req_t expected_mem(
	input coupe_pkg::cpu_bus_t b,
	input coupe_pkg::paging_t  p
);
	coupe_pkg::mem_req_t m;
	logic [1:0]          sec;
	logic                rom0;
	logic                rom1;
	logic                wp;
	logic                ext;
	logic [8:0]          base;
	sec  = b.addr[15:14];
	rom0 = ~p.lmpr[5] && sec == 2'd0;
	rom1 =  p.lmpr[6] && sec == 2'd3;
	wp   =  p.lmpr[7] && sec == 2'd0;
	ext  =  p.hmpr[7] && b.addr[15];
	base = sec[1] ? {4'd0, p.hmpr[4:0]} : {4'd0, p.lmpr[4:0]};
	if (ext) begin
		m.ram_page = {1'b1, b.addr[14] ? p.ext_d : p.ext_c};
	end else begin
		m.ram_page = base + {8'd0, sec[0]};
	end
	m.offset   = b.addr[13:0];
	m.rom_sel  = rom0 | rom1;
	m.rom_addr = {b.addr[15], b.addr[13:0]};
	m.ram_rd   = b.mreq & b.rd & ~m.rom_sel;
	m.ram_we   = b.mreq & b.wr & ~m.rom_sel & ~wp & ~(ext & p.ext_dis);
	return m;
endfunction

// Port read data for a low address byte
function automatic logic [7:0] expected_rd(
	input logic [7:0] port,
	input logic [7:0] lmpr,
	input logic [7:0] hmpr
);
	if (port == 8'hFA) begin
		return lmpr;
	end
	if (port == 8'hFB) begin
		return hmpr;
	end
	return 8'hFF;
endfunction

// One side of the audio mix
function automatic logic [15:0] expected_mix(
	input logic [7:0] psg,
	input logic       ear,
	input logic [7:0] vox
);
	logic [18:0] sum;
	// A byte repeated twice and moved up two places is the byte times 1028
	sum = 19'(psg * 1028 + ear * 131072 + vox * 1028);
	return sum[18:3];
endfunction

`endif

//--- dv/coupe_asic_tb.sv
/*
 * SAM Coupe ASIC core testbench
 * Drives port writes, port reads, memory accesses and audio samples,
 * and compares the DUT against shadow registers and reference functions.
 */

`timescale 1ns/100ps

module coupe_asic_tb;
	import coupe_pkg::*;

	`include "coupe_asic_model.svh"

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_RB         = 16;
	localparam int N_MAP        = 24;
	localparam int N_ACC        = 8;
	localparam int N_DAC        = 24;
	// Each operation takes at most 10 cycles
	localparam int NUM_OPS      = 16 + N_RB * 4 + 2 * ((N_MAP + 2) * (4 + N_ACC) + 4) + 9 + N_DAC * 5;
	localparam int LIMIT_CYCLES = NUM_OPS * 10 + 2 * RESET_CYCLES + 200;

	logic        clk_sys;
	logic        reset;
	cpu_bus_t    bus;
	logic        ext_ram_off;
	logic [7:0]  psg_l;
	logic [7:0]  psg_r;
	logic [7:0]  rd_data;
	mem_req_t    mem;
	logic [15:0] audio_l;
	logic [15:0] audio_r;

	// Shadow copy of the ASIC registers
	paging_t     sh_pg;
	logic        sh_ear;
	logic [7:0]  sh_lptd;
	logic        sh_strobe;
	logic [7:0]  sh_vox_l;
	logic [7:0]  sh_vox_r;

	// Pending expectations for the comparison process
	logic        mem_chk;
	logic        rd_chk;
	logic        aud_chk;
	mem_req_t    exp_mem;
	logic [7:0]  exp_rd;
	logic [15:0] exp_al;
	logic [15:0] exp_ar;
	int          errors;
	int          checks;

	coupe_asic uut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.ext_ram_off (ext_ram_off),
		.psg_l       (psg_l),
		.psg_r       (psg_r),
		.rd_data     (rd_data),
		.mem         (mem),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ====================
	// Stimulus tasks
	// ====================
	task automatic apply_reset(input logic off);
		@(negedge clk_sys);
		reset       = 1'b1;
		ext_ram_off = off;
		bus         = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset         = 1'b0;
		sh_pg.lmpr    = '0;
		sh_pg.hmpr    = '0;
		sh_pg.ext_dis = off;
		sh_ear        = 1'b0;
		sh_lptd       = '0;
		sh_strobe     = 1'b0;
		sh_vox_l      = '0;
		sh_vox_r      = '0;
	endtask

	// Held I/O write, then two idle cycles
	task automatic write_port(input logic [7:0] port, input logic [7:0] data, input int hold);
		logic [7:0] hi;
		hi = 8'($urandom);
		@(negedge clk_sys);
		bus      = '0;
		bus.addr = {hi, port};
		bus.data = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		@(negedge clk_sys);
		// Data after the first cycle is not part of the write event
		bus.data = ~data;
		repeat (hold - 1) @(negedge clk_sys);
		bus = '0;
		@(negedge clk_sys);
		case (port)
			PORT_LMPR:  sh_pg.lmpr = data;
			PORT_HMPR:  sh_pg.hmpr = data;
			PORT_EXT_C: sh_pg.ext_c = data;
			PORT_EXT_D: sh_pg.ext_d = data;
			PORT_BRDR:  sh_ear = data[4];
			PORT_LPTD:  sh_lptd = data;
			PORT_LPTS: begin
				if (!sh_strobe && data[0]) begin
					sh_vox_l = sh_lptd;
				end
				if (sh_strobe && !data[0]) begin
					sh_vox_r = sh_lptd;
				end
				sh_strobe = data[0];
			end
			default: ;
		endcase
	endtask

	task automatic read_port(input logic [7:0] port);
		@(negedge clk_sys);
		bus      = '0;
		bus.addr = {8'h00, port};
		bus.iorq = 1'b1;
		bus.rd   = 1'b1;
		exp_rd   = expected_rd(port, sh_pg.lmpr, sh_pg.hmpr);
		rd_chk   = 1'b1;
		@(negedge clk_sys);
		bus = '0;
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic is_wr);
		@(negedge clk_sys);
		bus      = '0;
		bus.addr = addr;
		bus.data = 8'($urandom);
		bus.mreq = 1'b1;
		bus.rd   = ~is_wr;
		bus.wr   = is_wr;
		exp_mem  = expected_mem(bus, sh_pg);
		mem_chk  = 1'b1;
	endtask

	task automatic check_audio(input logic [7:0] l, input logic [7:0] r);
		@(negedge clk_sys);
		bus     = '0;
		psg_l   = l;
		psg_r   = r;
		exp_al  = expected_mix(l, sh_ear, sh_vox_l);
		exp_ar  = expected_mix(r, sh_ear, sh_vox_r);
		aud_chk = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic map_round(input logic [7:0] l, input logic [7:0] h,
			input logic [7:0] c, input logic [7:0] d);
		write_port(PORT_LMPR, l, 3);
		write_port(PORT_HMPR, h, 3);
		write_port(PORT_EXT_C, c, 3);
		write_port(PORT_EXT_D, d, 3);
		repeat (N_ACC) mem_access(16'($urandom), 1'($urandom));
	endtask

	task automatic run_mapping();
		int i;
		// Page 31 plus one, ROM0 in section A
		map_round(8'h1F, 8'h1F, 8'h12, 8'hFE);
		// Write protect, ROM1 in section D, external RAM above 32K
		map_round(8'hFF, 8'h9F, 8'h34, 8'h56);
		mem_access(16'h8123, 1'b1);
		mem_access(16'hC456, 1'b1);
		mem_access(16'h8123, 1'b0);
		mem_access(16'hC456, 1'b0);
		for (i = 0; i < N_MAP; i++) begin
			map_round(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
		end
	endtask

	// ====================
	// Comparison
	// ====================
	initial begin
		forever begin
			@(posedge clk_sys);
			#1;
			if (mem_chk) begin
				checks++;
				assert (mem === exp_mem) else begin
					errors++;
					$display("error at %0.1f ns: mem = %h, expected %h",
						$realtime, mem, exp_mem);
				end
				mem_chk = 1'b0;
			end
			if (rd_chk) begin
				checks++;
				assert (rd_data === exp_rd) else begin
					errors++;
					$display("error at %0.1f ns: rd_data = %h, expected %h",
						$realtime, rd_data, exp_rd);
				end
				rd_chk = 1'b0;
			end
			if (aud_chk) begin
				checks++;
				assert (audio_l === exp_al) else begin
					errors++;
					$display("error at %0.1f ns: audio_l = %h, expected %h",
						$realtime, audio_l, exp_al);
				end
				assert (audio_r === exp_ar) else begin
					errors++;
					$display("error at %0.1f ns: audio_r = %h, expected %h",
						$realtime, audio_r, exp_ar);
				end
				aud_chk = 1'b0;
			end
		end
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ====================
	// Main sequence
	// ====================
	initial begin
		int i;
		reset       = 1'b1;
		bus         = '0;
		ext_ram_off = 1'b0;
		psg_l       = '0;
		psg_r       = '0;
		mem_chk     = 1'b0;
		rd_chk      = 1'b0;
		aud_chk     = 1'b0;
		errors      = 0;
		checks      = 0;
		sh_pg       = '0;
		void'($urandom(32'hb398_feaf));

		apply_reset(1'b0);
		read_port(PORT_LMPR);
		read_port(PORT_HMPR);
		read_port(8'h1F);
		check_audio(8'h00, 8'h00);

		// Paging registers read back, some writes held longer
		for (i = 0; i < N_RB; i++) begin
			write_port(PORT_LMPR, 8'($urandom), 3 + $urandom_range(0, 5));
			write_port(PORT_HMPR, 8'($urandom), 3);
			read_port(PORT_LMPR);
			read_port(PORT_HMPR);
		end

		run_mapping();
		apply_reset(1'b1);
		run_mapping();

		// Rising strobe, repeated strobe, falling strobe
		write_port(PORT_BRDR, 8'h10, 3);
		write_port(PORT_LPTD, 8'hA5, 3);
		write_port(PORT_LPTS, 8'h01, 3);
		check_audio(8'($urandom), 8'($urandom));
		write_port(PORT_LPTD, 8'h3C, 3);
		write_port(PORT_LPTS, 8'h01, 6);
		check_audio(8'($urandom), 8'($urandom));
		write_port(PORT_LPTS, 8'h00, 3);
		check_audio(8'($urandom), 8'($urandom));

		for (i = 0; i < N_DAC; i++) begin
			write_port(PORT_LPTD, 8'($urandom), 3);
			write_port(PORT_LPTS, 8'($urandom), 3);
			write_port(PORT_BRDR, 8'($urandom), 3);
			check_audio(8'($urandom), 8'($urandom));
		end

		repeat (4) @(negedge clk_sys);
		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- logic/asic_port_regs.sv
/*
 * ASIC port registers
 * Decodes write events into the paging, border, external RAM and
 * parallel DAC registers, and returns LMPR/HMPR on port reads.
 */

`timescale 1ns/100ps

module asic_port_regs (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             ext_ram_off,
	input  coupe_pkg::cpu_bus_t              bus,
	input  coupe_pkg::port_write_t           wr_evt,
	output coupe_pkg::paging_t               paging,
	output logic                             beeper,
	output logic [coupe_pkg::DATA_W-1:0]     dac_data,
	output logic                             dac_strobe_wr,
	output logic                             dac_strobe_bit,
	output logic [coupe_pkg::DATA_W-1:0]     rd_data
);
	import coupe_pkg::*;

	logic [DATA_W-1:0] lmpr;
	logic [DATA_W-1:0] hmpr;
	logic [DATA_W-1:0] ext_c;
	logic [DATA_W-1:0] ext_d;
	logic [DATA_W-1:0] lpt_data;
	logic              ext_dis;
	logic              brdr_ear;
	logic              port_rd;

	// ====================
	// Write decode
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr     <= '0;
			hmpr     <= '0;
			brdr_ear <= 1'b0;
			lpt_data <= '0;
		end else if (wr_evt.valid) begin
			case (wr_evt.port)
				PORT_LMPR: lmpr     <= wr_evt.data;
				PORT_HMPR: hmpr     <= wr_evt.data;
				// Only the EAR bit of the border port reaches this core
				PORT_BRDR: brdr_ear <= wr_evt.data[4];
				PORT_LPTD: lpt_data <= wr_evt.data;
				default: ;
			endcase
		end
	end

	// External RAM pages, written by software before first use
	always_ff @(posedge clk_sys) begin
		if (wr_evt.valid && wr_evt.port == PORT_EXT_C) begin
			ext_c <= wr_evt.data;
		end
		if (wr_evt.valid && wr_evt.port == PORT_EXT_D) begin
			ext_d <= wr_evt.data;
		end
	end

	// External RAM disable follows the board option while in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ext_dis <= ext_ram_off;
		end
	end

	assign paging = '{
		lmpr:    lmpr,
		hmpr:    hmpr,
		ext_c:   ext_c,
		ext_d:   ext_d,
		ext_dis: ext_dis
	};

	// ====================
	// Audio side
	// ====================
	assign beeper         = brdr_ear;
	assign dac_data       = lpt_data;
	assign dac_strobe_wr  = wr_evt.valid && (wr_evt.port == PORT_LPTS);
	assign dac_strobe_bit = wr_evt.data[0];

	// ====================
	// Port read-back
	// ====================
	assign port_rd = bus.iorq & bus.rd & ~bus.m1;

	always_comb begin
		rd_data = '1;
		if (port_rd) begin
			case (bus.addr[7:0])
				PORT_LMPR: rd_data = lmpr;
				PORT_HMPR: rd_data = hmpr;
				default:   rd_data = '1;
			endcase
		end
	end

endmodule

//--- logic/audio_out.sv
/*
 * Audio output
 * Two-channel parallel DAC latch and the registered mix of sound chip,
 * beeper and DAC samples.
 */

`timescale 1ns/100ps

module audio_out (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              beeper,
	input  logic [coupe_pkg::DATA_W-1:0]      dac_data,
	input  logic                              dac_strobe_wr,
	input  logic                              dac_strobe_bit,
	input  logic [coupe_pkg::DATA_W-1:0]      psg_l,
	input  logic [coupe_pkg::DATA_W-1:0]      psg_r,
	output logic [coupe_pkg::AUDIO_W-1:0]     audio_l,
	output logic [coupe_pkg::AUDIO_W-1:0]     audio_r
);
	import coupe_pkg::*;

	logic              strobe_prev;
	logic [DATA_W-1:0] vox_l;
	logic [DATA_W-1:0] vox_r;
	logic [MIX_W-1:0]  mix_l;
	logic [MIX_W-1:0]  mix_r;

	// One mixer side, scaled so each 8-bit source spans the full range
	function automatic logic [MIX_W-1:0] mix_side(
		input logic [DATA_W-1:0] psg,
		input logic              ear,
		input logic [DATA_W-1:0] vox
	);
		logic [MIX_W-1:0] psg_term;
		logic [MIX_W-1:0] ear_term;
		logic [MIX_W-1:0] vox_term;
		psg_term = {1'b0, psg, psg, 2'b00};
		ear_term = {1'b0, ear, 17'd0};
		vox_term = {1'b0, vox, vox, 2'b00};
		return psg_term + ear_term + vox_term;
	endfunction

	// ====================
	// DAC latch
	// ====================
	// Rising strobe loads left, falling strobe loads right
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_prev <= 1'b0;
			vox_l       <= '0;
			vox_r       <= '0;
		end else if (dac_strobe_wr) begin
			if (~strobe_prev & dac_strobe_bit) begin
				vox_l <= dac_data;
			end
			if (strobe_prev & ~dac_strobe_bit) begin
				vox_r <= dac_data;
			end
			strobe_prev <= dac_strobe_bit;
		end
	end

	// ====================
	// Mixer
	// ====================
	assign mix_l = mix_side(psg_l, beeper, vox_l);
	assign mix_r = mix_side(psg_r, beeper, vox_r);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l[MIX_W-1:MIX_W-AUDIO_W];
			audio_r <= mix_r[MIX_W-1:MIX_W-AUDIO_W];
		end
	end

endmodule

//--- logic/coupe_asic.sv
/*
 * SAM Coupe ASIC core
 * Port write capture, port registers, memory mapper and audio output.
 */

`timescale 1ns/100ps

module coupe_asic (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  coupe_pkg::cpu_bus_t           bus,
	input  logic                          ext_ram_off,
	input  logic [coupe_pkg::DATA_W-1:0]  psg_l,
	input  logic [coupe_pkg::DATA_W-1:0]  psg_r,
	output logic [coupe_pkg::DATA_W-1:0]  rd_data,
	output coupe_pkg::mem_req_t           mem,
	output logic [coupe_pkg::AUDIO_W-1:0] audio_l,
	output logic [coupe_pkg::AUDIO_W-1:0] audio_r
);
	import coupe_pkg::*;

	port_write_t       wr_evt;
	paging_t           paging;
	logic              beeper;
	logic [DATA_W-1:0] dac_data;
	logic              dac_strobe_wr;
	logic              dac_strobe_bit;

	port_write_capture u_capture (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.wr_evt  (wr_evt)
	);

	asic_port_regs u_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ext_ram_off    (ext_ram_off),
		.bus            (bus),
		.wr_evt         (wr_evt),
		.paging         (paging),
		.beeper         (beeper),
		.dac_data       (dac_data),
		.dac_strobe_wr  (dac_strobe_wr),
		.dac_strobe_bit (dac_strobe_bit),
		.rd_data        (rd_data)
	);

	memory_mapper u_mapper (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.paging  (paging),
		.mem     (mem)
	);

	audio_out u_audio (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.beeper         (beeper),
		.dac_data       (dac_data),
		.dac_strobe_wr  (dac_strobe_wr),
		.dac_strobe_bit (dac_strobe_bit),
		.psg_l          (psg_l),
		.psg_r          (psg_r),
		.audio_l        (audio_l),
		.audio_r        (audio_r)
	);

endmodule

//--- logic/coupe_pkg.sv
/*
 * SAM Coupe ASIC core package
 * Bus widths, ASIC port numbers and the structs passed between the
 * port capture, port register, memory mapper and audio stages.
 */

package coupe_pkg;

	// ====================
	// Widths
	// ====================
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 8;
	localparam int PAGE_W     = 9;
	localparam int OFFSET_W   = 14;
	localparam int ROM_ADDR_W = 15;
	localparam int AUDIO_W    = 16;
	localparam int MIX_W      = 19;

	// ====================
	// Port numbers
	// ====================
	// External RAM page registers
	localparam logic [7:0] PORT_EXT_C = 8'h80;
	localparam logic [7:0] PORT_EXT_D = 8'h81;

	// Parallel DAC data and strobe
	localparam logic [7:0] PORT_LPTD = 8'hE8;
	localparam logic [7:0] PORT_LPTS = 8'hE9;

	// Paging and border
	localparam logic [7:0] PORT_LMPR = 8'hFA;
	localparam logic [7:0] PORT_HMPR = 8'hFB;
	localparam logic [7:0] PORT_BRDR = 8'hFE;

	// ====================
	// Structs
	// ====================
	// CPU bus as active-high levels
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              mreq;
		logic              iorq;
		logic              rd;
		logic              wr;
		logic              m1;
	} cpu_bus_t;

	// One port write event, valid for a single cycle
	typedef struct packed {
		logic              valid;
		logic [7:0]        port;
		logic [DATA_W-1:0] data;
	} port_write_t;

	// Paging state seen by the memory mapper
	typedef struct packed {
		logic [DATA_W-1:0] lmpr;
		logic [DATA_W-1:0] hmpr;
		logic [DATA_W-1:0] ext_c;
		logic [DATA_W-1:0] ext_d;
		logic              ext_dis;
	} paging_t;

	// Mapped memory access
	typedef struct packed {
		logic [PAGE_W-1:0]     ram_page;
		logic [OFFSET_W-1:0]   offset;
		logic                  rom_sel;
		logic [ROM_ADDR_W-1:0] rom_addr;
		logic                  ram_rd;
		logic                  ram_we;
	} mem_req_t;

endpackage

//--- logic/memory_mapper.sv
/*
 * Memory mapper
 * Registered translation of CPU memory accesses into RAM page, offset,
 * ROM select and RAM read/write strobes.
 */

`timescale 1ns/100ps

module memory_mapper (
	input  logic                clk_sys,
	input  logic                reset,
	input  coupe_pkg::cpu_bus_t bus,
	input  coupe_pkg::paging_t  paging,
	output coupe_pkg::mem_req_t mem
);
	import coupe_pkg::*;

	logic [1:0]        section;
	logic              rom0_sel;
	logic              rom1_sel;
	logic              ram_wp;
	logic              ext_ram;
	logic              ext_ena;
	logic [PAGE_W-1:0] page_ab;
	logic [PAGE_W-1:0] page_cd;
	logic [PAGE_W-1:0] ram_page;
	mem_req_t          mem_d;
	mem_req_t          mem_q;

	assign section = bus.addr[15:14];

	// ROM in section A unless paged out, ROM in section D when paged in
	assign rom0_sel = ~paging.lmpr[5] & (section == 2'd0);
	assign rom1_sel =  paging.lmpr[6] & (section == 2'd3);
	assign ram_wp   =  paging.lmpr[7] & (section == 2'd0);
	assign ext_ram  =  paging.hmpr[7] & bus.addr[15];
	assign ext_ena  = ~(ext_ram & paging.ext_dis);

	// Full page width so page 31 plus one reaches page 32
	assign page_ab = PAGE_W'(paging.lmpr[4:0]);
	assign page_cd = PAGE_W'(paging.hmpr[4:0]);

	always_comb begin
		if (ext_ram) begin
			ram_page = bus.addr[14] ? {1'b1, paging.ext_d} : {1'b1, paging.ext_c};
		end else begin
			case (section)
				2'd0:    ram_page = page_ab;
				2'd1:    ram_page = page_ab + PAGE_W'(1);
				2'd2:    ram_page = page_cd;
				default: ram_page = page_cd + PAGE_W'(1);
			endcase
		end
	end

	always_comb begin
		mem_d.ram_page = ram_page;
		mem_d.offset   = bus.addr[OFFSET_W-1:0];
		mem_d.rom_sel  = rom0_sel | rom1_sel;
		mem_d.rom_addr = {bus.addr[15], bus.addr[OFFSET_W-1:0]};
		mem_d.ram_rd   = bus.mreq & bus.rd & ~(rom0_sel | rom1_sel);
		mem_d.ram_we   = bus.mreq & bus.wr & ~(rom0_sel | rom1_sel | ram_wp) & ext_ena;
	end

	// Strobes cleared in reset, address fields just follow the bus
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_q.ram_rd <= 1'b0;
			mem_q.ram_we <= 1'b0;
		end else begin
			mem_q <= mem_d;
		end
	end

	assign mem = mem_q;

	// No RAM write may escape while a ROM is mapped at the address
	a_no_we_on_rom : assert property (
		@(posedge clk_sys) disable iff (reset) !(mem_q.ram_we && mem_q.rom_sel)
	);

endmodule

//--- logic/port_write_capture.sv
/*
 * Port write capture
 * Turns the CPU's held I/O write level into one single-cycle write event
 * carrying the port number and data of the first cycle.
 */

`timescale 1ns/100ps

module port_write_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  coupe_pkg::cpu_bus_t    bus,
	output coupe_pkg::port_write_t wr_evt
);
	import coupe_pkg::*;

	logic              wr_level;
	logic              wr_level_q;
	logic              valid_q;
	logic [7:0]        port_q;
	logic [DATA_W-1:0] data_q;

	// I/O write outside an interrupt acknowledge
	assign wr_level = bus.iorq & bus.wr & ~bus.m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_level_q <= 1'b0;
			valid_q    <= 1'b0;
		end else begin
			wr_level_q <= wr_level;
			valid_q    <= wr_level & ~wr_level_q;
		end
	end

	// Payload taken from the first cycle of the access
	always_ff @(posedge clk_sys) begin
		if (wr_level & ~wr_level_q) begin
			port_q <= bus.addr[7:0];
			data_q <= bus.data;
		end
	end

	assign wr_evt = '{valid: valid_q, port: port_q, data: data_q};

	// A held write level never gives back-to-back events
	a_single_event : assert property (
		@(posedge clk_sys) disable iff (reset) valid_q |=> !valid_q
	);

endmodule
